// File: verilog/bmd_pkg.sv
// Shared types, register map and packet constants for the ADC DMA endpoint, imported by each module
package bmd_pkg;

    typedef logic [11:0] adc_sample_t;   // One ADC conversion
    typedef logic [31:0] dword_t;
    typedef logic [31:0] buf_addr_t;     // Host buffer address
    typedef logic [1:0]  reg_addr_t;

    localparam int NUM_CHAN = 2;         // Fixed by the ADC pins

    // --------------------------------------------------------------------------
    // Register map
    // --------------------------------------------------------------------------
    localparam reg_addr_t REG_CTRL      = 2'd0;
    localparam reg_addr_t REG_ADDR_PUSH = 2'd1;
    localparam reg_addr_t REG_ADDR_RET  = 2'd2;   // Read head, write pops
    localparam reg_addr_t REG_STATUS    = 2'd3;

    localparam int CTRL_INIT_BIT = 31;   // Self-clearing init reset
    localparam int ST_FREE_EMPTY = 0;
    localparam int ST_RET_EMPTY  = 1;
    localparam int ST_OVF_LSB    = 2;    // One sticky flag per channel
    localparam int ST_RET_FULL   = 4;

    // 3DW header with data, memory write
    localparam logic [6:0] MWR_FMT_TYPE = 7'b10_00000;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        dword_t    data;
    } reg_wr_t;

    typedef struct packed {
        dword_t td;
        logic   sof_n;
        logic   eof_n;
        logic   src_rdy_n;
    } ll_tx_t;

    typedef struct packed {
        dword_t word;    // FIFO head
        logic   ready;   // A whole payload is buffered
    } chan_word_t;

endpackage

// File: verilog/buffer_addr_fifo.sv
// Show-ahead FIFO of host buffer addresses, instanced as the free list and the return list
`timescale 1ns/100ps

module buffer_addr_fifo import bmd_pkg::*; #(
    parameter int ADDR_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clr_i,
    input  logic      push_i,
    input  buf_addr_t data_i,
    input  logic      pop_i,
    output buf_addr_t data_o,
    output logic      empty_o,
    output logic      full_o
);

    localparam int PW = (ADDR_DEPTH > 1) ? $clog2(ADDR_DEPTH) : 1;
    localparam int CW = $clog2(ADDR_DEPTH + 1);
    localparam logic [PW-1:0] LAST_PTR = PW'(ADDR_DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(ADDR_DEPTH);

    buf_addr_t     mem [ADDR_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign empty_o = (count == '0);
    assign full_o  = (count == FULL_CNT);
    assign data_o  = mem[rd_ptr];              // Head visible without a pop

    always_ff @(posedge clk) begin
        if (!rst_n || clr_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n || clr_i)
        !(push_i && full_o)) else $error("address FIFO pushed while full");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n || clr_i)
        !(pop_i && empty_o)) else $error("address FIFO popped while empty");

endmodule

// File: verilog/ep_ctrl_regs.sv
// Host register port of the endpoint: control, address push and pop, status and read-back
`timescale 1ns/100ps

module ep_ctrl_regs import bmd_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  reg_wr_t             reg_wr_i,
    input  reg_addr_t           rd_addr_i,
    output dword_t              rd_data_o,
    input  logic                free_empty_i,
    input  logic                ret_empty_i,
    input  logic                ret_full_i,
    input  buf_addr_t           ret_addr_i,
    input  logic [NUM_CHAN-1:0] overflow_i,
    output logic [NUM_CHAN-1:0] chan_en_o,
    output logic                init_rst_o,
    output logic                free_push_o,
    output buf_addr_t           free_data_o,
    output logic                ret_pop_o
);

    logic   wr_ctrl;
    dword_t status;

    // --------------------------------------------------------------------------
    // Write decode
    // --------------------------------------------------------------------------
    assign wr_ctrl     = reg_wr_i.en && (reg_wr_i.addr == REG_CTRL);
    assign free_push_o = reg_wr_i.en && (reg_wr_i.addr == REG_ADDR_PUSH);
    assign free_data_o = reg_wr_i.data;
    assign ret_pop_o   = reg_wr_i.en && (reg_wr_i.addr == REG_ADDR_RET);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chan_en_o  <= '0;
            init_rst_o <= 1'b0;
        end else begin
            init_rst_o <= wr_ctrl && reg_wr_i.data[CTRL_INIT_BIT];  // One-cycle pulse
            if (wr_ctrl) begin
                // Init reset also drops the channel enables
                chan_en_o <= reg_wr_i.data[CTRL_INIT_BIT] ? '0 : reg_wr_i.data[NUM_CHAN-1:0];
            end
        end
    end

    // --------------------------------------------------------------------------
    // Status and read-back
    // --------------------------------------------------------------------------
    always_comb begin
        status                         = '0;
        status[ST_FREE_EMPTY]          = free_empty_i;
        status[ST_RET_EMPTY]           = ret_empty_i;
        status[ST_OVF_LSB +: NUM_CHAN] = overflow_i;
        status[ST_RET_FULL]            = ret_full_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_o <= '0;
        end else begin
            case (rd_addr_i)
                REG_CTRL:     rd_data_o <= 32'(chan_en_o);
                REG_ADDR_RET: rd_data_o <= ret_addr_i;      // Head of the return list
                REG_STATUS:   rd_data_o <= status;
                default:      rd_data_o <= '0;              // Push register is write-only
            endcase
        end
    end

endmodule

// File: verilog/adc_capture.sv
// Brings the slow ADC clock into the system clock domain and strobes both channel samples
`timescale 1ns/100ps

module adc_capture import bmd_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       adc_clk_i,
    input  adc_sample_t                adc1_i,
    input  adc_sample_t                adc2_i,
    output logic                       sample_stb_o,
    output adc_sample_t [NUM_CHAN-1:0] samples_o
);

    logic adc_clk_s1;
    logic adc_clk_s2;
    logic adc_clk_d;      // Edge detector history
    logic adc_rise;

    assign adc_rise = adc_clk_s2 && !adc_clk_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            adc_clk_s1   <= 1'b0;
            adc_clk_s2   <= 1'b0;
            adc_clk_d    <= 1'b0;
            sample_stb_o <= 1'b0;
        end else begin
            adc_clk_s1   <= adc_clk_i;
            adc_clk_s2   <= adc_clk_s1;
            adc_clk_d    <= adc_clk_s2;
            sample_stb_o <= adc_rise;    // Third cycle after the ADC edge
        end
    end

    always_ff @(posedge clk) begin
        if (adc_rise) begin
            samples_o[0] <= adc1_i;
            samples_o[1] <= adc2_i;
        end
    end

endmodule

// File: verilog/sample_packer.sv
// Per-channel packer: pairs samples into dwords, buffers them and flags a full payload
`timescale 1ns/100ps

module sample_packer import bmd_pkg::*; #(
    parameter int PKT_DWORDS = 4,
    parameter int CHAN_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clr_i,
    input  logic        en_i,
    input  logic        sample_stb_i,
    input  adc_sample_t sample_i,
    input  logic        pop_i,
    output chan_word_t  chan_o,
    output logic        overflow_o
);

    localparam int PW = (CHAN_DEPTH > 1) ? $clog2(CHAN_DEPTH) : 1;
    localparam int CW = $clog2(CHAN_DEPTH + 1);
    localparam logic [PW-1:0] LAST_PTR = PW'(CHAN_DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(CHAN_DEPTH);
    localparam logic [CW-1:0] PKT_CNT  = CW'(PKT_DWORDS);

    dword_t        mem [CHAN_DEPTH];
    adc_sample_t   first_q;       // First sample of the pair
    logic          half_q;
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pair_done;
    logic          push;
    logic          do_pop;

    assign pair_done = sample_stb_i && en_i && half_q;
    assign push      = pair_done && (count != FULL_CNT);   // Dropped when full
    assign do_pop    = pop_i && (count != '0);

    always_comb begin
        chan_o.word  = mem[rd_ptr];
        chan_o.ready = (count >= PKT_CNT);
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clr_i) begin
            half_q     <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (!en_i) begin
                half_q <= 1'b0;          // Pairing restarts on enable
            end else if (sample_stb_i) begin
                half_q <= !half_q;
            end
            if (pair_done && (count == FULL_CNT)) begin
                overflow_o <= 1'b1;      // Sticky until init reset
            end
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (sample_stb_i && !half_q) begin
            first_q <= sample_i;
        end
        if (push) begin
            mem[wr_ptr] <= {4'h0, sample_i, 4'h0, first_q};   // Second sample high
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n || clr_i)
        !(pop_i && (count == '0))) else $error("sample FIFO popped while empty");

endmodule

// File: verilog/mwr_tx_engine.sv
// Transmit engine framing round-robin memory-write packets from the channel FIFOs
`timescale 1ns/100ps

module mwr_tx_engine import bmd_pkg::*; #(
    parameter int PKT_DWORDS = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clr_i,
    input  chan_word_t [NUM_CHAN-1:0] chan_i,
    input  logic [NUM_CHAN-1:0]       chan_en_i,
    output logic [NUM_CHAN-1:0]       chan_pop_o,
    input  buf_addr_t                 free_addr_i,
    input  logic                      free_empty_i,
    input  logic                      ret_full_i,
    output logic                      free_pop_o,
    output logic                      ret_push_o,
    input  logic [15:0]               completer_id_i,
    input  logic                      tdst_rdy_n_i,
    output ll_tx_t                    tx_o
);

    typedef enum logic [2:0] {IDLE, HDR0, HDR1, HDR2, DATA} tx_state_e;

    localparam int IW = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;
    localparam int CW = (PKT_DWORDS > 1) ? $clog2(PKT_DWORDS) : 1;
    localparam logic [CW-1:0] LAST_BEAT = CW'(PKT_DWORDS - 1);

    tx_state_e     state;
    logic [IW-1:0] rr_ptr;        // Channel searched first
    logic [IW-1:0] gnt_q;
    logic [IW-1:0] sel;
    logic [CW-1:0] beat_cnt;
    logic          any_elig;
    logic          start;
    logic          accept;
    logic          last_beat;
    logic          sof_n_q;
    logic          eof_n_q;
    logic          src_rdy_n_q;

    // --------------------------------------------------------------------------
    // Round-robin pick among enabled, ready channels
    // --------------------------------------------------------------------------
    always_comb begin : rr_pick
        int k;
        int idx;
        sel      = rr_ptr;
        any_elig = 1'b0;
        for (k = NUM_CHAN - 1; k >= 0; k--) begin   // Lowest offset wins last
            idx = (int'(rr_ptr) + k) % NUM_CHAN;
            if (chan_en_i[idx] && chan_i[idx].ready) begin
                sel      = IW'(idx);
                any_elig = 1'b1;
            end
        end
    end

    assign start      = (state == IDLE) && any_elig && !free_empty_i && !ret_full_i;
    assign accept     = !src_rdy_n_q && !tdst_rdy_n_i;
    assign last_beat  = (state == DATA) && (beat_cnt == LAST_BEAT);
    assign free_pop_o = accept && last_beat;   // Buffer recycled on eof
    assign ret_push_o = accept && last_beat;

    always_comb begin
        chan_pop_o = '0;
        if (accept && (state == DATA)) begin
            chan_pop_o[gnt_q] = 1'b1;
        end
    end

    always_comb begin
        case (state)
            HDR0:    tx_o.td = {1'b0, MWR_FMT_TYPE, 14'h0, 10'(PKT_DWORDS)};
            HDR1:    tx_o.td = {completer_id_i, 8'(gnt_q), 8'hFF};   // Tag is the channel
            HDR2:    tx_o.td = free_addr_i;
            DATA:    tx_o.td = chan_i[gnt_q].word;
            default: tx_o.td = '0;
        endcase
        tx_o.sof_n     = sof_n_q;
        tx_o.eof_n     = eof_n_q;
        tx_o.src_rdy_n = src_rdy_n_q;
    end

    // --------------------------------------------------------------------------
    // Packet FSM
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n || clr_i) begin
            state       <= IDLE;
            rr_ptr      <= '0;
            gnt_q       <= '0;
            beat_cnt    <= '0;
            sof_n_q     <= 1'b1;
            eof_n_q     <= 1'b1;
            src_rdy_n_q <= 1'b1;
        end else begin
            case (state)
                IDLE: if (start) begin
                    state       <= HDR0;
                    gnt_q       <= sel;
                    rr_ptr      <= (sel == IW'(NUM_CHAN - 1)) ? '0 : sel + 1'b1;
                    sof_n_q     <= 1'b0;
                    src_rdy_n_q <= 1'b0;
                end
                HDR0: if (accept) begin
                    state   <= HDR1;
                    sof_n_q <= 1'b1;
                end
                HDR1: if (accept) begin
                    state <= HDR2;
                end
                HDR2: if (accept) begin
                    state    <= DATA;
                    beat_cnt <= '0;
                    eof_n_q  <= (PKT_DWORDS > 1);
                end
                DATA: if (accept) begin
                    if (last_beat) begin
                        state       <= IDLE;
                        eof_n_q     <= 1'b1;
                        src_rdy_n_q <= 1'b1;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                        eof_n_q  <= (beat_cnt + 1'b1 != LAST_BEAT);
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_sof_in_hdr0: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_o.sof_n |-> (state == HDR0)) else $error("sof outside header beat 0");
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n || clr_i)
        (!tx_o.src_rdy_n && tdst_rdy_n_i) |=> $stable(tx_o))
        else $error("transmit beat changed while stalled");

endmodule

// File: verilog/bmd_dma_ep.sv
// Top level of the ADC bus-master DMA endpoint, connecting registers, lists, packers and engine
`timescale 1ns/100ps

module bmd_dma_ep import bmd_pkg::*; #(
    parameter int PKT_DWORDS = 4,
    parameter int CHAN_DEPTH = 8,
    parameter int ADDR_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  reg_wr_t     reg_wr_i,
    input  reg_addr_t   rd_addr_i,
    output dword_t      rd_data_o,
    input  logic        adc_clk_i,
    input  adc_sample_t adc1_i,
    input  adc_sample_t adc2_i,
    input  logic [15:0] cfg_completer_id_i,
    input  logic        tdst_rdy_n_i,
    output ll_tx_t      tx_o
);

    logic                       init_rst;
    logic [NUM_CHAN-1:0]        chan_en;
    logic [NUM_CHAN-1:0]        chan_pop;
    logic [NUM_CHAN-1:0]        overflow;
    chan_word_t [NUM_CHAN-1:0]  chan_words;
    adc_sample_t [NUM_CHAN-1:0] samples;
    logic                       sample_stb;
    logic                       free_push;
    buf_addr_t                  free_data;
    logic                       free_pop;
    buf_addr_t                  free_addr;
    logic                       free_empty;
    logic                       ret_push;
    logic                       ret_pop;
    buf_addr_t                  ret_addr;
    logic                       ret_empty;
    logic                       ret_full;

    // --------------------------------------------------------------------------
    // Host buffer address lists
    // --------------------------------------------------------------------------
    buffer_addr_fifo #(.ADDR_DEPTH(ADDR_DEPTH)) free_list_inst (
        .clk(clk), .rst_n(rst_n), .clr_i(init_rst),
        .push_i(free_push), .data_i(free_data),
        .pop_i(free_pop), .data_o(free_addr),
        .empty_o(free_empty), .full_o()          // Free list fill is host-managed
    );

    buffer_addr_fifo #(.ADDR_DEPTH(ADDR_DEPTH)) ret_list_inst (
        .clk(clk), .rst_n(rst_n), .clr_i(init_rst),
        .push_i(ret_push), .data_i(free_addr),   // Address of the packet just sent
        .pop_i(ret_pop), .data_o(ret_addr),
        .empty_o(ret_empty), .full_o(ret_full)
    );

    ep_ctrl_regs ep_ctrl_regs_inst (
        .clk(clk), .rst_n(rst_n),
        .reg_wr_i(reg_wr_i), .rd_addr_i(rd_addr_i), .rd_data_o(rd_data_o),
        .free_empty_i(free_empty), .ret_empty_i(ret_empty), .ret_full_i(ret_full),
        .ret_addr_i(ret_addr), .overflow_i(overflow),
        .chan_en_o(chan_en), .init_rst_o(init_rst),
        .free_push_o(free_push), .free_data_o(free_data), .ret_pop_o(ret_pop)
    );

    adc_capture adc_capture_inst (
        .clk(clk), .rst_n(rst_n), .adc_clk_i(adc_clk_i),
        .adc1_i(adc1_i), .adc2_i(adc2_i),
        .sample_stb_o(sample_stb), .samples_o(samples)
    );

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        sample_packer #(.PKT_DWORDS(PKT_DWORDS), .CHAN_DEPTH(CHAN_DEPTH)) sample_packer_inst (
            .clk(clk), .rst_n(rst_n), .clr_i(init_rst), .en_i(chan_en[i]),
            .sample_stb_i(sample_stb), .sample_i(samples[i]), .pop_i(chan_pop[i]),
            .chan_o(chan_words[i]), .overflow_o(overflow[i])
        );
    end

    mwr_tx_engine #(.PKT_DWORDS(PKT_DWORDS)) mwr_tx_engine_inst (
        .clk(clk), .rst_n(rst_n), .clr_i(init_rst),
        .chan_i(chan_words), .chan_en_i(chan_en), .chan_pop_o(chan_pop),
        .free_addr_i(free_addr), .free_empty_i(free_empty), .ret_full_i(ret_full),
        .free_pop_o(free_pop), .ret_push_o(ret_push),
        .completer_id_i(cfg_completer_id_i), .tdst_rdy_n_i(tdst_rdy_n_i), .tx_o(tx_o)
    );

endmodule

// File: dv/tb_bmd_dma_ep.sv
// Self-checking testbench for the ADC DMA endpoint, drives a stimulus table and models the packets
`timescale 1ns/100ps

module tb_bmd_dma_ep import bmd_pkg::*;;

    localparam int PKT_DWORDS     = 4;
    localparam int CHAN_DEPTH     = 8;
    localparam int ADDR_DEPTH     = 4;
    localparam int BEATS          = PKT_DWORDS + 3;
    localparam int NUM_ROWS       = 42;
    localparam int TIMEOUT_CYCLES = 2 * NUM_ROWS * 8 + 2000;
    localparam buf_addr_t ADDR_BASE = 32'h8000_0000;
    localparam logic [15:0] COMPLETER_ID = 16'hA5C3;

    typedef struct packed {
        adc_sample_t adc1;
        adc_sample_t adc2;
        logic        throttle;   // Random destination back-pressure
    } stim_row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    reg_wr_t     reg_wr;
    reg_addr_t   rd_addr;
    dword_t      rd_data;
    logic        adc_clk;
    adc_sample_t adc1;
    adc_sample_t adc2;
    logic [15:0] completer_id;
    logic        tdst_rdy_n = 1'b0;
    ll_tx_t      tx;

    stim_row_t   stim_table [NUM_ROWS];
    logic        throttle_on = 1'b0;
    int          cycle_cnt = 0;
    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    int          pkt_count = 0;

    // Reference model state
    logic [NUM_CHAN-1:0] model_en;
    logic                model_half [NUM_CHAN];
    adc_sample_t         model_first [NUM_CHAN];
    logic                model_ovf [NUM_CHAN];
    dword_t              model_fifo [NUM_CHAN][$];
    int                  model_rr;
    buf_addr_t           model_free [$];
    buf_addr_t           model_ret [$];
    int                  exp_chan [$];
    buf_addr_t           exp_addr [$];
    dword_t              exp_payload [$];

    // Monitor state
    dword_t beats [BEATS];
    int     beat_idx = 0;
    logic   stalled_q = 1'b0;
    ll_tx_t prev_tx;

    bmd_dma_ep #(
        .PKT_DWORDS(PKT_DWORDS), .CHAN_DEPTH(CHAN_DEPTH), .ADDR_DEPTH(ADDR_DEPTH)
    ) bmd_dma_ep_inst (
        .clk(clk), .rst_n(rst_n),
        .reg_wr_i(reg_wr), .rd_addr_i(rd_addr), .rd_data_o(rd_data),
        .adc_clk_i(adc_clk), .adc1_i(adc1), .adc2_i(adc2),
        .cfg_completer_id_i(completer_id), .tdst_rdy_n_i(tdst_rdy_n), .tx_o(tx)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles waiting for the DUT", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(posedge clk) begin : dst_throttle
        tdst_rdy_n <= throttle_on && (($urandom % 2) == 1);
    end

    task automatic check_value(input string name, input dword_t expected, input dword_t actual);
        if (expected !== actual) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s expected %08h, got %08h", $time, name, expected,
                     actual);
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    task automatic reset_model();
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            model_fifo[ch].delete();
            model_half[ch] = 1'b0;
            model_ovf[ch]  = 1'b0;
        end
        model_free.delete();
        model_ret.delete();
        model_rr = 0;
        model_en = '0;
    endtask

    task automatic model_sample(input stim_row_t row);
        adc_sample_t s;
        dword_t      w;
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            if (model_en[ch]) begin
                s = (ch == 0) ? row.adc1 : row.adc2;
                if (!model_half[ch]) begin
                    model_first[ch] = s;
                    model_half[ch]  = 1'b1;
                end else begin
                    w         = '0;
                    w[11:0]   = model_first[ch];   // First of the pair low
                    w[27:16]  = s;
                    model_half[ch] = 1'b0;
                    if (model_fifo[ch].size() < CHAN_DEPTH) begin
                        model_fifo[ch].push_back(w);
                    end else begin
                        model_ovf[ch] = 1'b1;
                    end
                end
            end
        end
    endtask

    // Starts every packet the engine can issue, in round-robin order
    task automatic predict_packets();
        int        pick;
        int        ch;
        buf_addr_t a;
        pick = 0;
        while (pick >= 0) begin
            pick = -1;
            if (model_free.size() > 0 && model_ret.size() < ADDR_DEPTH) begin
                for (int k = 0; k < NUM_CHAN; k++) begin
                    ch = (model_rr + k) % NUM_CHAN;
                    if (pick < 0 && model_en[ch] && model_fifo[ch].size() >= PKT_DWORDS) begin
                        pick = ch;
                    end
                end
            end
            if (pick >= 0) begin
                a = model_free.pop_front();
                exp_chan.push_back(pick);
                exp_addr.push_back(a);
                model_ret.push_back(a);
                for (int i = 0; i < PKT_DWORDS; i++) begin
                    exp_payload.push_back(model_fifo[pick].pop_front());
                end
                model_rr = (pick + 1) % NUM_CHAN;
            end
        end
    endtask

    function automatic dword_t expected_status();
        dword_t s;
        s    = '0;
        s[0] = (model_free.size() == 0);
        s[1] = (model_ret.size() == 0);
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            s[2 + ch] = model_ovf[ch];
        end
        s[4] = (model_ret.size() == ADDR_DEPTH);
        return s;
    endfunction

    // ------------------------------------------------------------------------
    // Packet monitor
    // ------------------------------------------------------------------------
    task automatic compare_packet();
        int        ch;
        buf_addr_t a;
        dword_t    hdr0;
        if (exp_chan.size() == 0) begin
            other_cnt++;
            $display("ERROR at %0t: a packet was sent when none was expected", $time);
        end else begin
            ch          = exp_chan.pop_front();
            a           = exp_addr.pop_front();
            hdr0        = '0;
            hdr0[30:24] = MWR_FMT_TYPE;
            hdr0[9:0]   = 10'(PKT_DWORDS);
            check_value("tx_o.td beat 0", hdr0, beats[0]);
            check_value("tx_o.td beat 1", {completer_id, 8'(ch), 8'hFF}, beats[1]);
            check_value("tx_o.td beat 2", a, beats[2]);
            for (int i = 0; i < PKT_DWORDS; i++) begin
                check_value("tx_o.td payload", exp_payload.pop_front(), beats[3 + i]);
            end
        end
    endtask

    always @(posedge clk) begin : monitor
        if (rst_n) begin
            if (stalled_q) begin
                check_value("tx_o.td stalled", prev_tx.td, tx.td);
                check_value("tx_o.sof_n stalled", 32'(prev_tx.sof_n), 32'(tx.sof_n));
                check_value("tx_o.eof_n stalled", 32'(prev_tx.eof_n), 32'(tx.eof_n));
                check_value("tx_o.src_rdy_n stalled", 32'(prev_tx.src_rdy_n),
                            32'(tx.src_rdy_n));
            end
            stalled_q = !tx.src_rdy_n && tdst_rdy_n;
            prev_tx   = tx;
            if (!tx.src_rdy_n && !tdst_rdy_n) begin        // Beat accepted
                check_value("tx_o.sof_n", 32'(beat_idx != 0), 32'(tx.sof_n));
                check_value("tx_o.eof_n", 32'(beat_idx != BEATS - 1), 32'(tx.eof_n));
                if (beat_idx < BEATS) begin
                    beats[beat_idx] = tx.td;
                end
                if (!tx.eof_n) begin
                    check_value("beat count", 32'(BEATS), 32'(beat_idx + 1));
                    compare_packet();
                    beat_idx = 0;
                    pkt_count <= pkt_count + 1;
                end else begin
                    beat_idx++;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Host port and ADC drivers
    // ------------------------------------------------------------------------
    task automatic write_reg(input reg_addr_t a, input dword_t d);
        @(posedge clk);
        reg_wr <= '{en: 1'b1, addr: a, data: d};
        @(posedge clk);
        reg_wr <= '0;
    endtask

    task automatic read_reg(input reg_addr_t a, output dword_t d);
        @(posedge clk);
        rd_addr <= a;
        @(posedge clk);
        @(posedge clk);
        d = rd_data;    // Registered one cycle after the address
    endtask

    task automatic write_ctrl(input dword_t d);
        write_reg(REG_CTRL, d);
        if (d[31]) begin
            reset_model();
        end else begin
            model_en = d[NUM_CHAN-1:0];
            for (int ch = 0; ch < NUM_CHAN; ch++) begin
                if (!model_en[ch]) begin
                    model_half[ch] = 1'b0;
                end
            end
        end
    endtask

    task automatic push_addr(input buf_addr_t a);
        write_reg(REG_ADDR_PUSH, a);
        model_free.push_back(a);
    endtask

    task automatic check_status();
        dword_t d;
        read_reg(REG_STATUS, d);
        check_value("rd_data_o status", expected_status(), d);
    endtask

    task automatic readback_returns();
        dword_t    d;
        buf_addr_t a;
        while (model_ret.size() > 0) begin
            a = model_ret.pop_front();
            read_reg(REG_ADDR_RET, d);
            check_value("rd_data_o return head", a, d);
            write_reg(REG_ADDR_RET, '0);     // Pop
        end
        check_status();
    endtask

    // Each row: ADC clock low for 4 cycles, then high for 4
    task automatic apply_rows(input int first, input int count);
        for (int r = first; r < first + count; r++) begin
            model_sample(stim_table[r]);
            predict_packets();
            @(posedge clk);
            adc1        <= stim_table[r].adc1;
            adc2        <= stim_table[r].adc2;
            throttle_on <= stim_table[r].throttle;
            adc_clk     <= 1'b0;
            repeat (3) @(posedge clk);
            @(posedge clk);
            adc_clk <= 1'b1;
            repeat (3) @(posedge clk);
        end
    endtask

    task automatic wait_packets(input int n);
        while (pkt_count < n) begin
            @(posedge clk);
        end
    endtask

    task automatic fill_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            stim_table[r].adc1     = adc_sample_t'($urandom);
            stim_table[r].adc2     = adc_sample_t'($urandom);
            stim_table[r].throttle = 1'b0;
        end
        for (int r = 16; r < 24; r++) begin
            stim_table[r]          = stim_table[r - 8];  // Same samples as rows 8..15
            stim_table[r].throttle = 1'b1;
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin : main
        dword_t d;
        void'($urandom(78));
        rst_n        <= 1'b0;
        reg_wr       <= '0;
        rd_addr      <= REG_STATUS;
        adc_clk      <= 1'b0;
        adc1         <= '0;
        adc2         <= '0;
        completer_id <= COMPLETER_ID;
        reset_model();
        fill_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Idle after reset
        check_value("tx_o.src_rdy_n", 32'd1, 32'(tx.src_rdy_n));
        check_status();

        // Channel 0 alone, one buffer
        push_addr(ADDR_BASE);
        write_ctrl(32'h1);
        apply_rows(0, 8);
        wait_packets(1);
        repeat (20) @(posedge clk);
        check_value("packet count", 32'd1, 32'(pkt_count));
        readback_returns();
        write_ctrl(32'h8000_0000);

        // Both channels ready together, then again under back-pressure
        push_addr(ADDR_BASE + 32'h1000);
        push_addr(ADDR_BASE + 32'h2000);
        write_ctrl(32'h3);
        apply_rows(8, 8);
        wait_packets(3);
        readback_returns();
        write_ctrl(32'h8000_0000);

        push_addr(ADDR_BASE + 32'h1000);
        push_addr(ADDR_BASE + 32'h2000);
        write_ctrl(32'h3);
        apply_rows(16, 8);
        wait_packets(5);
        throttle_on <= 1'b0;
        readback_returns();
        write_ctrl(32'h8000_0000);

        // Channel 1 overflow with no buffer
        write_ctrl(32'h2);
        apply_rows(24, 18);
        repeat (10) @(posedge clk);
        check_value("packet count", 32'd5, 32'(pkt_count));
        check_status();
        write_ctrl(32'h8000_0000);
        check_status();
        read_reg(REG_CTRL, d);
        check_value("rd_data_o control", 32'h0, d);

        if (exp_chan.size() != 0) begin
            other_cnt++;
            $display("ERROR: %0d expected packets were never sent", exp_chan.size());
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
verilog/bmd_pkg.sv
verilog/buffer_addr_fifo.sv
verilog/ep_ctrl_regs.sv
verilog/adc_capture.sv
verilog/sample_packer.sv
verilog/mwr_tx_engine.sv
verilog/bmd_dma_ep.sv
dv/tb_bmd_dma_ep.sv

// File: run.sh
#!/bin/sh
# Build and run the endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_bmd_dma_ep \
    --Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
